// ==== flist.f ====
+incdir+verif
rtl/jtagPkg.sv
rtl/JtagStateMachine.sv
rtl/JtagInstrReg.sv
rtl/JtagDataRegs.sv
rtl/JtagRequestGen.sv
rtl/JtagPort.sv
verif/JtagPortTb.sv

// ==== rtl/JtagDataRegs.sv ====
// ID, bypass and access data registers with capture, shift and TDO select
`timescale 1ns/10ps

module JtagDataRegs (
	input  logic                 i_TCK,
	input  logic                 i_reset,
	input  logic                 i_TDI,
	input  logic                 i_shiftDr,
	input  logic                 i_captureDr,
	input  jtagPkg::jtagInstr_t  i_instr,
	input  logic                 i_shiftIr,
	input  logic                 i_irTdo,
	input  jtagPkg::accessWord_u i_rspWord,   // Response view for capture

	output jtagPkg::accessWord_u o_accessWord, // Request view after shift
	output logic                 o_TDO
);

	logic [jtagPkg::DATA_WIDTH-1:0] idReg;
	logic                           bypassReg;
	jtagPkg::accessWord_u           accessReg;

	logic selId, selAccess; // Decoded DR select with bypass otherwise
	logic drTdo;

	assign selId     = (i_instr == jtagPkg::IDCODE);
	assign selAccess = (i_instr == jtagPkg::READ) || (i_instr == jtagPkg::WRITE);

	////////////////////////////////////////////////////////////
	// ID and bypass registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_TCK) begin
		if (i_reset) begin
			idReg     <= jtagPkg::ID_CODE;
			bypassReg <= 1'b0;
		end else if (i_captureDr) begin
			if (selId) begin
				idReg <= jtagPkg::ID_CODE;
			end else if (!selAccess) begin
				bypassReg <= 1'b0; // Bypass and unknown codes
			end
		end else if (i_shiftDr) begin
			if (selId) begin
				idReg <= {i_TDI, idReg[jtagPkg::DATA_WIDTH-1:1]};
			end else if (!selAccess) begin
				bypassReg <= i_TDI; // One-bit delay
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Access register
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_TCK) begin
		if (i_captureDr && selAccess) begin
			accessReg.rsp <= i_rspWord.rsp; // Status and last rdata
		end else if (i_shiftDr && selAccess) begin
			accessReg <= jtagPkg::accessWord_u'(
				{i_TDI, accessReg[jtagPkg::ACCESS_WIDTH-1:1]});
		end
	end

	assign o_accessWord = accessReg; // Read as req view by the request generator

	// TDO mux giving zero outside the shift states
	always_comb begin
		if (selId) begin
			drTdo = idReg[0];
		end else if (selAccess) begin
			drTdo = accessReg[0];
		end else begin
			drTdo = bypassReg;
		end

		if (i_shiftIr) begin
			o_TDO = i_irTdo;
		end else if (i_shiftDr) begin
			o_TDO = drTdo;
		end else begin
			o_TDO = 1'b0;
		end
	end

endmodule

// ==== rtl/JtagInstrReg.sv ====
// Instruction shift register and latched current instruction
`timescale 1ns/10ps

module JtagInstrReg (
	input  logic i_TCK,
	input  logic i_reset,
	input  logic i_TDI,
	input  logic i_shiftIr,
	input  logic i_updateIr,

	output jtagPkg::jtagInstr_t o_instr, // Active instruction
	output logic                o_irTdo  // LSB out while shifting
);

	logic [jtagPkg::IR_WIDTH-1:0] irShift; // Shift stage not yet active

	////////////////////////////////////////////////////////////
	// Shift stage and update latch
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_TCK) begin
		if (i_reset) begin
			irShift <= '0;
			o_instr <= jtagPkg::IDCODE; // ID readable straight after reset
		end else begin
			if (i_shiftIr) begin
				irShift <= {i_TDI, irShift[jtagPkg::IR_WIDTH-1:1]}; // TDI into MSB
			end
			if (i_updateIr) begin
				case (irShift)
					jtagPkg::IDCODE,
					jtagPkg::WRITE,
					jtagPkg::READ,
					jtagPkg::BYPASS: o_instr <= jtagPkg::jtagInstr_t'(irShift);
					default:         o_instr <= jtagPkg::BYPASS; // Unknown opcode
				endcase
			end
		end
	end

	assign o_irTdo = irShift[0];

endmodule

// ==== rtl/JtagPort.sv ====
// Top level joining state machine, IR, data registers and request generator
`timescale 1ns/10ps

module JtagPort (
	// JTAG pins
	input  logic             i_TCK,
	input  logic             i_TMS,
	input  logic             i_TDI,
	input  logic             i_reset,
	output logic             o_TDO,

	// Register bus request and response
	output jtagPkg::busReq_t o_busReq,
	output logic             o_busReqValid,
	input  logic             i_busReqReady,
	input  jtagPkg::busRsp_t i_busRsp,
	input  logic             i_busRspValid
);

	////////////////////////////////////////////////////////////
	// Internal wires
	////////////////////////////////////////////////////////////
	logic shiftIr, shiftDr, captureDr, updateIr, updateDr; // FSM strobes
	logic irTdo;

	jtagPkg::jtagInstr_t  instr;
	jtagPkg::accessWord_u accessWord; // Shifted in as request view
	jtagPkg::accessWord_u rspWord;    // Status and rdata as response view

	////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////
	JtagStateMachine i_JtagStateMachine (
		.i_TCK       (i_TCK),
		.i_reset     (i_reset),
		.i_TMS       (i_TMS),
		.o_shiftIr   (shiftIr),
		.o_shiftDr   (shiftDr),
		.o_captureDr (captureDr),
		.o_updateIr  (updateIr),
		.o_updateDr  (updateDr)
	);

	JtagInstrReg i_JtagInstrReg (
		.i_TCK      (i_TCK),
		.i_reset    (i_reset),
		.i_TDI      (i_TDI),
		.i_shiftIr  (shiftIr),
		.i_updateIr (updateIr),
		.o_instr    (instr),
		.o_irTdo    (irTdo)
	);

	JtagDataRegs i_JtagDataRegs (
		.i_TCK        (i_TCK),
		.i_reset      (i_reset),
		.i_TDI        (i_TDI),
		.i_shiftDr    (shiftDr),
		.i_captureDr  (captureDr),
		.i_instr      (instr),
		.i_shiftIr    (shiftIr),
		.i_irTdo      (irTdo),
		.i_rspWord    (rspWord),
		.o_accessWord (accessWord),
		.o_TDO        (o_TDO)
	);

	JtagRequestGen i_JtagRequestGen (
		.i_TCK         (i_TCK),
		.i_reset       (i_reset),
		.i_updateDr    (updateDr),
		.i_captureDr   (captureDr),
		.i_instr       (instr),
		.i_accessWord  (accessWord),
		.i_busReqReady (i_busReqReady),
		.i_busRsp      (i_busRsp),
		.i_busRspValid (i_busRspValid),
		.o_busReq      (o_busReq),
		.o_busReqValid (o_busReqValid),
		.o_rspWord     (rspWord)
	);

endmodule

// ==== rtl/JtagRequestGen.sv ====
// Bus request issue on DR update, response store and sticky status
`timescale 1ns/10ps

module JtagRequestGen (
	input  logic                 i_TCK,
	input  logic                 i_reset,
	input  logic                 i_updateDr,
	input  logic                 i_captureDr,
	input  jtagPkg::jtagInstr_t  i_instr,
	input  jtagPkg::accessWord_u i_accessWord,  // Request view
	input  logic                 i_busReqReady,
	input  jtagPkg::busRsp_t     i_busRsp,
	input  logic                 i_busRspValid,

	output jtagPkg::busReq_t     o_busReq,
	output logic                 o_busReqValid,
	output jtagPkg::accessWord_u o_rspWord      // Response view for capture
);

	jtagPkg::accessStatus_t         status;
	logic [jtagPkg::DATA_WIDTH-1:0] rdata; // Last read data
	logic                           accessUpdate;

	assign accessUpdate = i_updateDr &&
		((i_instr == jtagPkg::READ) || (i_instr == jtagPkg::WRITE));

	////////////////////////////////////////////////////////////
	// Request side
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_TCK) begin
		if (i_reset) begin
			o_busReqValid <= 1'b0;
		end else if (accessUpdate && !status.busy) begin
			o_busReqValid <= 1'b1; // Held until accepted
		end else if (o_busReqValid && i_busReqReady) begin
			o_busReqValid <= 1'b0;
		end
	end

	// Request payload stays stable while valid is high
	always_ff @(posedge i_TCK) begin
		if (accessUpdate && !status.busy) begin
			o_busReq.write <= (i_instr == jtagPkg::WRITE);
			o_busReq.addr  <= i_accessWord.req.addr;
			o_busReq.wdata <= i_accessWord.req.wdata; // Ignored on READ
		end
	end

	////////////////////////////////////////////////////////////
	// Response and sticky status
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_TCK) begin
		if (i_reset) begin
			status <= '0;
			rdata  <= '0;
		end else begin
			if (i_captureDr) begin
				status.done    <= 1'b0; // Read-to-clear flags
				status.overrun <= 1'b0;
				status.error   <= 1'b0;
			end
			if (accessUpdate) begin
				if (status.busy) begin
					status.overrun <= 1'b1; // Update dropped
				end else begin
					status.busy <= 1'b1;
				end
			end
			if (i_busRspValid) begin // No ready on this side
				status.busy  <= 1'b0;
				status.done  <= 1'b1;
				status.error <= i_busRsp.error;
				rdata        <= i_busRsp.rdata;
			end
		end
	end

	assign o_rspWord.rsp.status = status;
	assign o_rspWord.rsp.rdata  = rdata;

endmodule

// ==== rtl/JtagStateMachine.sv ====
// 3-bit JTAG port FSM with shift, capture and update strobes
`timescale 1ns/10ps

module JtagStateMachine (
	input  logic i_TCK,
	input  logic i_reset,
	input  logic i_TMS,

	output logic o_shiftIr,   // IR shifts on this edge
	output logic o_shiftDr,   // Selected DR shifts on this edge
	output logic o_captureDr, // DSEL to DSHFT edge
	output logic o_updateIr,  // Edge leaving UPDIR
	output logic o_updateDr   // Edge leaving UPDDR
);

	////////////////////////////////////////////////////////////
	// State register
	////////////////////////////////////////////////////////////
	jtagPkg::jtagState_t stateQ;
	logic [2:0]          stateD;
	logic [2:0]          nextState1XX, nextState0XX;
	logic [2:0]          nextState10X, nextState00X;

	always_ff @(posedge i_TCK) begin
		if (i_reset) begin
			stateQ <= jtagPkg::IDLE;
		end else begin
			stateQ <= jtagPkg::jtagState_t'(stateD);
		end
	end

	////////////////////////////////////////////////////////////
	// Next state with one mux level per state bit
	////////////////////////////////////////////////////////////
	// DSEL goes to DSHFT or IDLE and ISHFT stays or goes to UPDIR
	assign nextState10X = stateQ[0] ? {1'b0, ~i_TMS, 1'b0} : {1'b1, i_TMS, 1'b0};
	assign nextState1XX = stateQ[1] ? 3'b000 : nextState10X; // Both updates back to IDLE

	// ISEL goes to DSEL or ISHFT and IDLE goes to ISEL or stays
	assign nextState00X = stateQ[0] ? {1'b1, 1'b0, i_TMS} : {1'b0, 1'b0, i_TMS};
	// DSHFT stays or exits through UPDDR
	assign nextState0XX = stateQ[1] ? {i_TMS, 1'b1, i_TMS} : nextState00X;

	assign stateD = stateQ[2] ? nextState1XX : nextState0XX;

	////////////////////////////////////////////////////////////
	// Strobes valid for the coming rising edge
	////////////////////////////////////////////////////////////
	assign o_shiftIr   = (stateQ == jtagPkg::ISHFT); // Exit edge shifts too
	assign o_shiftDr   = (stateQ == jtagPkg::DSHFT);
	assign o_captureDr = (stateQ == jtagPkg::DSEL) && !i_TMS;
	assign o_updateIr  = (stateQ == jtagPkg::UPDIR);
	assign o_updateDr  = (stateQ == jtagPkg::UPDDR);

endmodule

// ==== rtl/jtagPkg.sv ====
// Port states, opcodes, register widths, ID code, bus request/response structs, access word union
package jtagPkg;

	////////////////////////////////////////////////////////////
	// Widths and constants
	////////////////////////////////////////////////////////////
	localparam int IR_WIDTH     = 4;
	localparam int ADDR_WIDTH   = 8;
	localparam int DATA_WIDTH   = 32;
	localparam int ACCESS_WIDTH = 40; // Status/addr byte plus data word

	localparam logic [DATA_WIDTH-1:0] ID_CODE = 32'h1A5C0001;

	// Compact 3-bit port FSM encodings
	typedef enum logic [2:0] {
		IDLE  = 3'b000,
		ISEL  = 3'b001,
		DSHFT = 3'b010,
		ISHFT = 3'b100,
		DSEL  = 3'b101,
		UPDIR = 3'b110,
		UPDDR = 3'b111
	} jtagState_t;

	// Unlisted codes fall back to BYPASS at IR update
	typedef enum logic [IR_WIDTH-1:0] {
		IDCODE = 4'b0001,
		WRITE  = 4'b0010,
		READ   = 4'b0011,
		BYPASS = 4'b1111
	} jtagInstr_t;

	////////////////////////////////////////////////////////////
	// Bus side
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                  write; // 1 for WRITE, 0 for READ
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] wdata;
	} busReq_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] rdata;
		logic                  error;
	} busRsp_t;

	// Sticky access status with done in bit 0
	typedef struct packed {
		logic [3:0] reserved; // Always zero
		logic       error;
		logic       busy;
		logic       overrun;
		logic       done;
	} accessStatus_t;

	// Same 40 bits as request going in and response coming out
	typedef union packed {
		struct packed {
			logic [ADDR_WIDTH-1:0] addr;
			logic [DATA_WIDTH-1:0] wdata;
		} req;
		struct packed {
			accessStatus_t         status;
			logic [DATA_WIDTH-1:0] rdata;
		} rsp;
	} accessWord_u;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the JtagPort testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
	--top-module JtagPortTb -Mdir obj_dir -o simJtagPort -f flist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simJtagPort > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi
exit 0

// ==== verif/jtagTbTasks.svh ====
// Pin driving, TAP shift sequences, typed compare tasks and the directed test tasks

task automatic failRun(input string msg);
	$display("%s", msg);
	$display("SIMULATION FAILED");
	$fatal(1, "Stopped at first failure");
endtask

task automatic nextCycle();
	@(posedge tck);
	#0.5; // Just past the edge
endtask

task automatic tckStep(input logic tmsBit, input logic tdiBit);
	tms = tmsBit;
	tdi = tdiBit;
	nextCycle();
endtask

// IDLE, ISEL, ISHFT, out through UPDIR
task automatic jtagShiftIr(input logic [3:0] din, output logic [3:0] dout);
	logic [3:0] pending;
	pending = din;
	dout    = '0;
	tckStep(1'b1, 1'b0);
	tckStep(1'b0, 1'b0);
	for (int i = 0; i < 4; i++) begin
		dout = {tdo, dout[3:1]};
		tckStep(i == 3, pending[0]); // TMS high on the last bit
		pending = pending >> 1;
	end
	tckStep(1'b0, 1'b0); // Instruction active after this edge
endtask

// IDLE, ISEL, DSEL, capture, shift, out through UPDDR
task automatic jtagShiftDr(input logic [39:0] din, input int nBits, output logic [39:0] dout);
	logic [39:0] pending;
	pending = din;
	dout    = '0;
	tckStep(1'b1, 1'b0);
	tckStep(1'b1, 1'b0);
	tckStep(1'b0, 1'b0); // Capture edge
	for (int i = 0; i < nBits; i++) begin
		dout = {tdo, dout[39:1]}; // TDO sampled before the shifting edge
		tckStep(i == nBits - 1, pending[0]);
		pending = pending >> 1;
	end
	dout = dout >> (40 - nBits); // Align short shifts to bit 0
	tckStep(1'b0, 1'b0);         // Update edge
endtask

task automatic awaitResponses(input int count);
	while (rspCount < count) begin
		tckStep(1'b0, 1'b0);
	end
endtask

////////////////////////////////////////////////////////////
// Expected values and compare tasks
////////////////////////////////////////////////////////////
function automatic jtagPkg::accessStatus_t makeStatus(input logic done, input logic overrun,
	input logic busy, input logic error);
	makeStatus         = '0;
	makeStatus.done    = done;
	makeStatus.overrun = overrun;
	makeStatus.busy    = busy;
	makeStatus.error   = error;
endfunction

function automatic jtagPkg::busReq_t makeReq(input logic write, input logic [7:0] addr,
	input logic [31:0] wdata);
	makeReq.write = write;
	makeReq.addr  = addr;
	makeReq.wdata = wdata;
endfunction

task automatic checkWord(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	if (actual !== expected) begin
		failRun($sformatf("CHECK FAILED %s expected %08h actual %08h", name, expected, actual));
	end
endtask

task automatic checkStatus(input string name, input jtagPkg::accessStatus_t expected,
	input jtagPkg::accessStatus_t actual);
	if (actual !== expected) begin
		failRun($sformatf("CHECK FAILED %s expected %02h actual %02h", name, expected, actual));
	end
endtask

task automatic checkReq(input string name, input jtagPkg::busReq_t expected,
	input jtagPkg::busReq_t actual);
	if (actual !== expected) begin
		failRun($sformatf("CHECK FAILED %s expected %0b/%02h/%08h actual %0b/%02h/%08h",
			name, expected.write, expected.addr, expected.wdata,
			actual.write, actual.addr, actual.wdata));
	end
endtask

task automatic checkNextReq(input string name, input jtagPkg::busReq_t expected);
	if (readPtr >= acceptLog.size()) begin
		failRun($sformatf("Request for %s never reached the bus", name));
	end else begin
		checkReq(name, expected, acceptLog[readPtr]);
		readPtr++;
	end
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////
task automatic testIdcode();
	logic [39:0] dout;
	logic [3:0]  irOut;
	jtagShiftDr(40'h0, 32, dout); // Reset instruction is IDCODE
	checkWord("idcode after reset", 32'h1A5C0001, dout[31:0]);
	jtagShiftIr(4'b0001, irOut);
	jtagShiftDr(40'h0, 32, dout);
	checkWord("idcode instruction", 32'h1A5C0001, dout[31:0]);
endtask

task automatic testBypass();
	logic [39:0] dout;
	logic [3:0]  irOut;
	logic [31:0] pattern;
	pattern = 32'hC3A596E1;
	jtagShiftIr(4'b1111, irOut);
	checkWord("ir shift out", 32'h1, {28'h0, irOut}); // Previous IDCODE leaves the IR
	jtagShiftDr({8'h00, pattern}, 32, dout);
	checkWord("bypass delay", {pattern[30:0], 1'b0}, dout[31:0]); // Captured 0 leads
endtask

task automatic testWrite();
	logic [39:0] dout;
	logic [3:0]  irOut;
	jtagShiftIr(4'b0010, irOut);
	jtagShiftDr({8'h3C, 32'hDEADBEEF}, 40, dout); // Addr on top and wdata below
	issuedCount++;
	awaitResponses(issuedCount);
	checkNextReq("write request", makeReq(1'b1, 8'h3C, 32'hDEADBEEF));
	// Status read under READ, which re-reads the same address
	jtagShiftIr(4'b0011, irOut);
	jtagShiftDr({8'h3C, 32'h0}, 40, dout);
	checkStatus("write status", makeStatus(1'b1, 1'b0, 1'b0, 1'b0), dout[39:32]);
	issuedCount++;
	awaitResponses(issuedCount);
	checkNextReq("read after write", makeReq(1'b0, 8'h3C, 32'h0));
endtask

task automatic testReadBack();
	logic [39:0] dout;
	jtagShiftDr({8'h21, 32'h0}, 40, dout);
	checkWord("read data", 32'hDEADBEEF, dout[31:0]);
	checkStatus("read status", makeStatus(1'b1, 1'b0, 1'b0, 1'b0), dout[39:32]);
	issuedCount++;
	awaitResponses(issuedCount);
	checkNextReq("second read", makeReq(1'b0, 8'h21, 32'h0));
endtask

task automatic testOverrunError();
	logic [39:0] dout;
	holdReady = 1'b1;
	jtagShiftDr({8'h3C, 32'h0}, 40, dout); // Stays pending
	issuedCount++;
	jtagShiftDr({8'h55, 32'h0}, 40, dout); // Dropped while busy
	checkStatus("pending status", makeStatus(1'b0, 1'b0, 1'b1, 1'b0), dout[39:32]);
	if (!busReqValid || acceptLog.size() != readPtr) begin
		failRun("Held request lost its valid or was accepted while ready was low");
	end
	checkReq("held request", makeReq(1'b0, 8'h3C, 32'h0), busReq);
	holdReady = 1'b0;
	awaitResponses(issuedCount);
	checkNextReq("overrun survivor", makeReq(1'b0, 8'h3C, 32'h0));
	jtagShiftDr({8'hF0, 32'h0}, 40, dout); // Faulting address
	checkStatus("overrun status", makeStatus(1'b1, 1'b1, 1'b0, 1'b0), dout[39:32]);
	issuedCount++;
	awaitResponses(issuedCount);
	checkNextReq("error read", makeReq(1'b0, 8'hF0, 32'h0));
	holdReady = 1'b1; // Keep the next response away from the clear check
	jtagShiftDr({8'h3C, 32'h0}, 40, dout);
	checkStatus("error status", makeStatus(1'b1, 1'b0, 1'b0, 1'b1), dout[39:32]);
	issuedCount++;
	jtagShiftDr({8'h3C, 32'h0}, 40, dout);
	checkStatus("cleared status", makeStatus(1'b0, 1'b0, 1'b1, 1'b0), dout[39:32]);
	holdReady = 1'b0;
	awaitResponses(issuedCount);
	checkNextReq("last read", makeReq(1'b0, 8'h3C, 32'h0));
	if (busReqValid || acceptLog.size() != readPtr) begin
		failRun("A dropped update produced a bus request");
	end
endtask

// ==== verif/JtagPortTb.sv ====
// JtagPort testbench top with clock, reset, timeout, bus responder model and test sequence
`timescale 1ns/10ps

module JtagPortTb;

	////////////////////////////////////////////////////////////
	// DUT signals and testbench state
	////////////////////////////////////////////////////////////
	logic             tck;
	logic             tms;
	logic             tdi;
	logic             reset;
	logic             tdo;
	jtagPkg::busReq_t busReq;
	logic             busReqValid;
	logic             busReqReady;
	jtagPkg::busRsp_t busRsp;
	logic             busRspValid;

	logic             holdReady;      // Responder keeps ready low while set
	int               issuedCount;    // Requests the tests expect on the bus
	int               rspCount;       // Responses returned so far
	int               readPtr;        // Next logged request to compare
	jtagPkg::busReq_t acceptLog[$];   // Accepted requests, in order
	logic [31:0]      memory [0:255]; // Register space behind the bus

	JtagPort i_JtagPort (
		.i_TCK         (tck),
		.i_TMS         (tms),
		.i_TDI         (tdi),
		.i_reset       (reset),
		.o_TDO         (tdo),
		.o_busReq      (busReq),
		.o_busReqValid (busReqValid),
		.i_busReqReady (busReqReady),
		.i_busRsp      (busRsp),
		.i_busRspValid (busRspValid)
	);

	`include "jtagTbTasks.svh"

	// 4 ns TCK
	initial begin
		tck = 1'b0;
		forever #2 tck = ~tck;
	end

	// Run limit well above the summed shift lengths and response delays
	initial begin
		int cycleCount;
		cycleCount = 0;
		forever begin
			@(posedge tck);
			cycleCount++;
			if (cycleCount >= 4000) begin
				failRun("Timeout, the test sequence did not finish within 4000 TCK cycles");
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Bus responder with random ready delay and a late response
	////////////////////////////////////////////////////////////
	initial begin
		int               readyDelay;
		int               rspDelay;
		jtagPkg::busReq_t req;
		void'($urandom(32'hbf7e));
		busReqReady = 1'b0;
		busRspValid = 1'b0;
		busRsp      = '0;
		rspCount    = 0;
		for (int a = 0; a < 256; a++) begin
			memory[a[7:0]] = {a[7:0], ~a[7:0], 8'h5A, a[7:0] ^ 8'hC3}; // Unique per address
		end
		forever begin
			nextCycle();
			if (busReqValid && !holdReady) begin
				readyDelay = $urandom % 6; // 0 to 5 cycles
				repeat (readyDelay) nextCycle();
				busReqReady = 1'b1;
				req         = busReq; // Stable while valid
				nextCycle();          // Transfer edge
				busReqReady = 1'b0;
				acceptLog.push_back(req);
				if (req.write) begin
					memory[req.addr] = req.wdata;
					busRsp.rdata     = '0; // Writes return no data
				end else begin
					busRsp.rdata = memory[req.addr];
				end
				busRsp.error = (req.addr >= 8'hF0); // Top 16 addresses fault
				rspDelay     = 1 + $urandom % 4;    // 1 to 4 cycles
				repeat (rspDelay - 1) nextCycle();
				busRspValid = 1'b1;
				@(negedge tck);
				rspCount++; // Counted before the edge that samples it
				nextCycle();
				busRspValid = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Reset and test sequence
	////////////////////////////////////////////////////////////
	initial begin
		tms         = 1'b0;
		tdi         = 1'b0;
		reset       = 1'b1;
		holdReady   = 1'b0;
		issuedCount = 0;
		readPtr     = 0;
		repeat (4) @(posedge tck);
		#0.5;
		reset = 1'b0;

		testIdcode();
		testBypass();
		testWrite();
		testReadBack();
		testOverrunError();

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
